//--- src/pb_pkg.sv
`default_nettype none

package pb_pkg;

    localparam int clks_per_bit      = 16;   // UART bit period in clocks
    localparam int cmd_word_len      = 11;   // Includes the trailing comma
    localparam int param_bytes       = 4;
    localparam int max_line_len      = 32;   // Bytes beyond this are dropped
    localparam int bus_strobe_cycles = 4;

    localparam logic [7:0] ascii_cr = 8'h0D;
    localparam logic [7:0] ascii_lf = 8'h0A;

    localparam logic [8*cmd_word_len-1:0] cmd_write_word = "pb_i_write,";
    localparam logic [8*cmd_word_len-1:0] cmd_read_word  = "pb_i__read,";
    localparam logic [15:0]               ok_text        = "OK";
    localparam logic [31:0]               oops_text      = "oops";

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_BAD
    } cmd_op_t;

    // Unknown characters decode as zero
    function automatic logic [3:0] ascii_to_nibble(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return c[3:0];
        end
        if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
            return c[3:0] + 4'd9;            // 'A' and 'a' both end in 1
        end
        return 4'h0;
    endfunction

    function automatic logic [7:0] nibble_to_ascii(input logic [3:0] n);
        if (n < 4'd10) begin
            return {4'h3, n};
        end
        return 8'h37 + {4'h0, n};           // Upper case A-F
    endfunction

endpackage

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    import pb_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                         state;
    logic [$clog2(clks_per_bit)-1:0]   cnt;
    logic [2:0]                        bit_idx;
    logic                              rx_meta;
    logic                              rx_sync;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_meta  <= 1'b1;                // Line idles high
            rx_sync  <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == clks_per_bit/2 - 1) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // Reject glitches
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == clks_per_bit - 1) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == clks_per_bit - 1) begin
                        rx_valid <= rx_sync;         // Framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clock) begin
        if (state == RX_DATA && cnt == clks_per_bit - 1) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);
    import pb_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t                         state;
    logic [$clog2(clks_per_bit)-1:0]   cnt;
    logic [2:0]                        bit_idx;
    logic [7:0]                        shift;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (tx_valid) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == clks_per_bit - 1) begin
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == clks_per_bit - 1) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == clks_per_bit - 1) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == TX_IDLE && tx_valid) begin
            shift <= tx_byte;                // Capture on handshake
        end else if (state == TX_DATA && cnt == clks_per_bit - 1) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    assign tx_ready = (state == TX_IDLE);

    always_comb begin
        case (state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = shift[0];
            default:  tx = 1'b1;             // Idle and stop bit
        endcase
    end

endmodule

`default_nettype wire

//--- src/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [7:0]       rx_byte,
    input  logic             rx_valid,
    input  logic             reply_done,
    output logic             cmd_valid,
    output pb_pkg::cmd_op_t  cmd_op,
    output logic [31:0]      cmd_params
);
    import pb_pkg::*;

    typedef enum logic [1:0] {
        PS_COLLECT,
        PS_LOAD,
        PS_MATCH,
        PS_BUSY
    } ps_state_t;

    ps_state_t                           state;
    logic [7:0]                          line_buf [max_line_len];
    logic [$clog2(max_line_len):0]       wr_ptr;
    logic [8*cmd_word_len-1:0]           cmd_word;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= PS_COLLECT;
            wr_ptr    <= '0;
            cmd_valid <= 1'b0;
            cmd_op    <= OP_BAD;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                PS_COLLECT: begin
                    if (rx_valid) begin
                        if (rx_byte == ascii_lf) begin
                            state <= PS_LOAD;
                        end else if (wr_ptr < max_line_len) begin
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                    end
                end
                PS_LOAD: begin
                    wr_ptr <= '0;
                    state  <= PS_MATCH;
                end
                PS_MATCH: begin
                    cmd_valid <= 1'b1;
                    state     <= PS_BUSY;
                    if (cmd_word == cmd_write_word) begin
                        cmd_op <= OP_WRITE;
                    end else if (cmd_word == cmd_read_word) begin
                        cmd_op <= OP_READ;
                    end else begin
                        cmd_op <= OP_BAD;
                    end
                end
                PS_BUSY: begin
                    if (reply_done) begin            // Input ignored until the answer is out
                        state <= PS_COLLECT;
                    end
                end
                default: state <= PS_COLLECT;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == PS_COLLECT && rx_valid && rx_byte != ascii_lf && wr_ptr < max_line_len) begin
            line_buf[wr_ptr[$clog2(max_line_len)-1:0]] <= rx_byte;
        end
    end

    // Word and hex pairs are taken at fixed offsets from the line start
    always_ff @(posedge clock) begin
        if (state == PS_LOAD) begin
            for (int i = 0; i < cmd_word_len; i++) begin
                cmd_word[8*(cmd_word_len-1-i) +: 8] <= line_buf[i];
            end
            for (int i = 0; i < param_bytes; i++) begin
                cmd_params[8*(param_bytes-1-i) +: 8] <= {
                    ascii_to_nibble(line_buf[cmd_word_len + 2*i]),
                    ascii_to_nibble(line_buf[cmd_word_len + 2*i + 1])
                };                                   // Byte 0 lands in the top byte
            end
        end
    end

endmodule

`default_nettype wire

//--- src/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  pb_pkg::cmd_op_t  cmd_op,
    input  logic [31:0]      cmd_params,
    input  logic [7:0]       data_in,
    output logic [2:0]       addr,
    output logic [7:0]       data_out,
    output logic             data_oe,
    output logic             rd,
    output logic             wr,
    output logic [31:0]      rd_bytes,
    output logic             seq_done
);
    import pb_pkg::*;

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_SETUP,
        SQ_STROBE,
        SQ_GAP
    } sq_state_t;

    sq_state_t                               state;
    logic [$clog2(param_bytes)-1:0]          acc;       // Current access, also the address
    logic [$clog2(bus_strobe_cycles)-1:0]    strb_cnt;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SQ_IDLE;
            acc      <= '0;
            strb_cnt <= '0;
            data_oe  <= 1'b0;
            rd       <= 1'b0;
            wr       <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            case (state)
                SQ_IDLE: begin
                    if (cmd_valid) begin
                        if (cmd_op == OP_BAD) begin
                            seq_done <= 1'b1;        // Nothing to run on the bus
                        end else begin
                            acc     <= '0;
                            data_oe <= (cmd_op == OP_WRITE);
                            state   <= SQ_SETUP;
                        end
                    end
                end
                SQ_SETUP: begin
                    strb_cnt <= '0;
                    rd       <= (cmd_op == OP_READ);
                    wr       <= (cmd_op == OP_WRITE);
                    state    <= SQ_STROBE;
                end
                SQ_STROBE: begin
                    strb_cnt <= strb_cnt + 1'b1;
                    if (strb_cnt == bus_strobe_cycles - 1) begin
                        rd      <= 1'b0;
                        wr      <= 1'b0;
                        data_oe <= 1'b0;
                        state   <= SQ_GAP;
                        if (acc == param_bytes - 1) begin
                            seq_done <= 1'b1;        // Lines up with the last gap cycle
                        end
                    end
                end
                SQ_GAP: begin
                    if (acc == param_bytes - 1) begin
                        state <= SQ_IDLE;
                    end else begin
                        acc     <= acc + 1'b1;
                        data_oe <= (cmd_op == OP_WRITE);
                        state   <= SQ_SETUP;
                    end
                end
                default: state <= SQ_IDLE;
            endcase
        end
    end

    // Read data is sampled on the last strobe cycle
    always_ff @(posedge clock) begin
        if (state == SQ_STROBE && strb_cnt == bus_strobe_cycles - 1 && cmd_op == OP_READ) begin
            rd_bytes[8*(param_bytes-1-acc) +: 8] <= data_in;
        end
    end

    assign addr     = 3'(acc);
    assign data_out = cmd_params[8*(param_bytes-1-acc) +: 8];

endmodule

`default_nettype wire

//--- src/reply_builder.sv
`timescale 1ns/1ps
`default_nettype none

module reply_builder (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             seq_done,
    input  pb_pkg::cmd_op_t  cmd_op,
    input  logic [31:0]      rd_bytes,
    input  logic             tx_ready,
    output logic [7:0]       tx_byte,
    output logic             tx_valid,
    output logic             reply_done
);
    import pb_pkg::*;

    typedef enum logic {
        RB_IDLE,
        RB_SEND
    } rb_state_t;

    rb_state_t                   state;
    logic [4:0]                  idx;        // Character position in the answer
    logic [4:0]                  last_idx;
    logic [8*cmd_word_len-1:0]   word;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RB_IDLE;
            idx        <= '0;
            reply_done <= 1'b0;
        end else begin
            reply_done <= 1'b0;
            case (state)
                RB_IDLE: begin
                    idx <= '0;
                    if (seq_done) begin
                        state <= RB_SEND;
                    end
                end
                RB_SEND: begin
                    if (tx_ready) begin
                        if (idx == last_idx) begin
                            reply_done <= 1'b1;
                            state      <= RB_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= RB_IDLE;
            endcase
        end
    end

    assign tx_valid = (state == RB_SEND);
    assign word     = (cmd_op == OP_READ) ? cmd_read_word : cmd_write_word;

    always_comb begin
        case (cmd_op)
            OP_WRITE: last_idx = 5'(cmd_word_len + 3);                  // Word, OK, CR, LF
            OP_READ:  last_idx = 5'(cmd_word_len + 2*param_bytes + 1);  // Word, hex, CR, LF
            default:  last_idx = 5'd5;                                  // oops, CR, LF
        endcase
    end

    always_comb begin
        tx_byte = ascii_lf;                          // Last character of every answer
        if (cmd_op == OP_BAD) begin
            if (idx < 5'd4) begin
                tx_byte = oops_text[8*(3-idx) +: 8];
            end else if (idx == 5'd4) begin
                tx_byte = ascii_cr;
            end
        end else if (idx < cmd_word_len) begin
            tx_byte = word[8*(cmd_word_len-1-idx) +: 8];
        end else if (cmd_op == OP_WRITE) begin
            if (idx < cmd_word_len + 2) begin
                tx_byte = ok_text[8*(cmd_word_len+1-idx) +: 8];
            end else if (idx == cmd_word_len + 2) begin
                tx_byte = ascii_cr;
            end
        end else begin
            // High nibble of byte 0 goes out first
            if (idx < cmd_word_len + 2*param_bytes) begin
                tx_byte = nibble_to_ascii(rd_bytes[4*(cmd_word_len+2*param_bytes-1-idx) +: 4]);
            end else if (idx == cmd_word_len + 2*param_bytes) begin
                tx_byte = ascii_cr;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pb_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module pb_bridge_top (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       uart_rx_pin,
    output logic       uart_tx_pin,
    inout  wire  [7:0] data_pins,
    output logic [2:0] addr,
    output logic       rd,
    output logic       wr
);
    import pb_pkg::*;

    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        cmd_valid;
    cmd_op_t     cmd_op;
    logic [31:0] cmd_params;
    logic [7:0]  data_out;
    logic        data_oe;
    logic [31:0] rd_bytes;
    logic        seq_done;
    logic [7:0]  tx_byte;
    logic        tx_valid;
    logic        tx_ready;
    logic        reply_done;

    uart_rx u_uart_rx (
        .clock    (clock),
        .rst_n    (rst_n),
        .rx       (uart_rx_pin),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_parser u_cmd_parser (
        .clock      (clock),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .reply_done (reply_done),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_params (cmd_params)
    );

    bus_sequencer u_bus_sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_params (cmd_params),
        .data_in    (data_pins),
        .addr       (addr),
        .data_out   (data_out),
        .data_oe    (data_oe),
        .rd         (rd),
        .wr         (wr),
        .rd_bytes   (rd_bytes),
        .seq_done   (seq_done)
    );

    reply_builder u_reply_builder (
        .clock      (clock),
        .rst_n      (rst_n),
        .seq_done   (seq_done),
        .cmd_op     (cmd_op),
        .rd_bytes   (rd_bytes),
        .tx_ready   (tx_ready),
        .tx_byte    (tx_byte),
        .tx_valid   (tx_valid),
        .reply_done (reply_done)
    );

    uart_tx u_uart_tx (
        .clock    (clock),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (uart_tx_pin)
    );

    assign data_pins = data_oe ? data_out : 8'bz;   // Released for reads and idle

endmodule

`default_nettype wire

//--- bench/pb_uart_tasks.svh
// 8N1 frames with one bit per clks_per_bit cycles and changes on falling edges
task automatic send_byte(input logic [7:0] b);
    uart_rx_pin = 1'b0;                     // Start bit
    repeat (clks_per_bit) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
        uart_rx_pin = b[i];
        repeat (clks_per_bit) @(negedge clock);
    end
    uart_rx_pin = 1'b1;                     // Stop bit
    repeat (clks_per_bit) @(negedge clock);
endtask

task automatic send_line(input string text);
    for (int i = 0; i < text.len(); i++) begin
        send_byte(text[i]);
    end
    send_byte(8'h0A);                       // Line feed ends the command
endtask

task automatic receive_byte(output logic [7:0] b);
    @(negedge clock);
    while (uart_tx_pin !== 1'b0) begin
        @(negedge clock);
    end
    repeat (clks_per_bit/2) @(negedge clock);   // Middle of the start bit
    for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clock);
        b[i] = uart_tx_pin;
    end
    repeat (clks_per_bit) @(negedge clock);
    checks++;
    assert (uart_tx_pin === 1'b1) else begin
        errors++;
        $display("Reply byte %02h had no stop bit on the tx line", b);
    end
endtask

// Whole answer up to and including its LF
task automatic collect_reply(output string s);
    logic [7:0] b;
    s = "";
    do begin
        receive_byte(b);
        s = $sformatf("%s%c", s, b);
    end while (b != 8'h0A);
endtask

//--- bench/pb_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pb_bridge_tb;
    import pb_pkg::*;

    localparam int clk_period  = 100;
    localparam int cycle_limit = 80000;     // Twice 6 lines of about 41 bytes at 160 cycles

    logic       clock = 1'b0;
    logic       rst_n;
    logic       uart_rx_pin;
    wire        uart_tx_pin;
    wire  [7:0] data_pins;
    wire  [2:0] addr;
    wire        rd;
    wire        wr;

    logic [7:0] board_mem [8];
    logic [2:0] wr_addr_q [$];
    logic [7:0] wr_data_q [$];
    int         rd_strobes;
    int         wr_strobes;
    time        wr_rise;

    string      name_q [$];
    string      exp_q  [$];
    string      act_q  [$];

    int         cycles;
    int         checks;
    int         errors;

    pb_bridge_top UUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .uart_rx_pin (uart_rx_pin),
        .uart_tx_pin (uart_tx_pin),
        .data_pins   (data_pins),
        .addr        (addr),
        .rd          (rd),
        .wr          (wr)
    );

    always #(clk_period/2) clock = ~clock;

    // Board registers preset from the full address
    initial begin
        for (int i = 0; i < 8; i++) begin
            board_mem[i] = 8'h3C ^ 8'(i * 41);
        end
    end

    always @(posedge wr) begin
        board_mem[addr] <= data_pins;       // Latch on the rising strobe
    end

    assign data_pins = rd ? board_mem[addr] : 8'bz;

    always @(posedge rd) begin
        rd_strobes++;
    end

    // Write monitor
    always @(posedge wr) begin
        wr_strobes++;
        wr_rise = $time;
        wr_addr_q.push_back(addr);
        wr_data_q.push_back(data_pins);
        $display("[%0t] bus write addr %0d data %02h", $time, addr, data_pins);
    end

    always @(negedge wr) begin
        if (rst_n) begin                    // X to 0 at time zero is no strobe
            checks++;
            assert (($time - wr_rise) / clk_period == bus_strobe_cycles) else begin
                errors++;
                $display("** Error: wr_strobe_width: expected %0d actual %0d",
                         bus_strobe_cycles, ($time - wr_rise) / clk_period);
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles while waiting for the bridge", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic string hex_text(logic [31:0] value);
        string digits;
        string s;
        digits = "0123456789ABCDEF";
        s      = "";
        for (int i = 7; i >= 0; i--) begin
            s = $sformatf("%s%c", s, digits[value[4*i +: 4]]);
        end
        return s;
    endfunction

    function automatic string visible(string s);
        string v;
        v = "";
        for (int i = 0; i < s.len(); i++) begin
            if (s[i] == 8'h0D) begin
                v = {v, "<CR>"};
            end else if (s[i] == 8'h0A) begin
                v = {v, "<LF>"};
            end else begin
                v = $sformatf("%s%c", v, s[i]);
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word();
        return {board_mem[0], board_mem[1], board_mem[2], board_mem[3]};
    endfunction

    // Reply rules of the bridge
    function automatic string expected_reply(string cmd_text, logic [31:0] mem_bytes);
        string word;
        string reply;
        word = cmd_text.substr(0, 10);
        if (word == "pb_i_write,") begin
            reply = {word, "OK\r\n"};
        end else if (word == "pb_i__read,") begin
            reply = {word, hex_text(mem_bytes), "\r\n"};
        end else begin
            reply = "oops\r\n";
        end
        return reply;
    endfunction

    task automatic queue_reply_check(string name, string expected, string actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);            // Pushed last so it wakes the checker
    endtask

    task automatic run_command(string text, output string reply);
        fork
            send_line(text);
            collect_reply(reply);
        join
    endtask

    task automatic check_writes(string name, logic [31:0] params);
        checks++;
        assert (wr_data_q.size() == param_bytes) else begin
            errors++;
            $display("** Error: %s: expected %0d writes actual %0d",
                     name, param_bytes, wr_data_q.size());
        end
        for (int i = 0; i < param_bytes && i < wr_data_q.size(); i++) begin
            checks++;
            assert (wr_addr_q[i] == i && wr_data_q[i] == params[8*(3-i) +: 8]) else begin
                errors++;
                $display("** Error: %s write %0d: expected %0d/%02h actual %0d/%02h", name, i,
                         i, params[8*(3-i) +: 8], wr_addr_q[i], wr_data_q[i]);
            end
        end
    endtask

    task automatic write_and_check(string name, logic [31:0] params, bit lower);
        string digits;
        string text;
        string reply;
        digits = hex_text(params);
        if (lower) begin
            digits = digits.tolower();
        end
        text = {"pb_i_write,", digits};
        wr_addr_q.delete();
        wr_data_q.delete();
        run_command(text, reply);
        check_writes(name, params);
        queue_reply_check(name, expected_reply(text, mem_word()), reply);
    endtask

    task automatic read_and_check(string name);
        string text;
        string reply;
        text = "pb_i__read,00000000";
        run_command(text, reply);
        queue_reply_check(name, expected_reply(text, mem_word()), reply);
    endtask

    // Reply checker
    initial begin
        string t_name;
        string t_exp;
        string t_act;
        forever begin
            wait (act_q.size() > 0);
            t_name = name_q.pop_front();
            t_exp  = exp_q.pop_front();
            t_act  = act_q.pop_front();
            checks++;
            assert (t_act == t_exp) else begin
                errors++;
                $display("** Error: %s: expected \"%s\" actual \"%s\"",
                         t_name, visible(t_exp), visible(t_act));
            end
        end
    end

    initial begin
        string       reply;
        logic [31:0] params;
        int          rd_before;
        int          wr_before;

        void'($urandom(32'he91959ad));
        rst_n       = 1'b0;
        uart_rx_pin = 1'b1;                 // UART line idles high
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        checks++;
        assert (uart_tx_pin === 1'b1 && rd === 1'b0 && wr === 1'b0 && data_pins === 8'hzz)
        else begin
            errors++;
            $display("** Error: reset_state: expected tx 1 rd 0 wr 0 data zz actual %b %b %b %h",
                     uart_tx_pin, rd, wr, data_pins);
        end

        params = $urandom();
        write_and_check("write_upper", params, 1'b0);
        write_and_check("write_lower", params, 1'b1);
        read_and_check("read_back");

        rd_before = rd_strobes;
        wr_before = wr_strobes;
        run_command("pb_i_erase,12345678", reply);
        queue_reply_check("bad_command", expected_reply("pb_i_erase,12345678", 0), reply);
        checks++;
        assert (rd_strobes == rd_before && wr_strobes == wr_before) else begin
            errors++;
            $display("** Error: bad_command_strobes: expected 0 actual %0d",
                     (rd_strobes - rd_before) + (wr_strobes - wr_before));
        end

        params = $urandom();
        write_and_check("write_second", params, 1'b0);
        read_and_check("read_second");

        wait (act_q.size() == 0);
        @(negedge clock);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    `include "pb_uart_tasks.svh"

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
src/pb_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_parser.sv
src/bus_sequencer.sv
src/reply_builder.sv
src/pb_bridge_top.sv
bench/pb_bridge_tb.sv

//--- Bender.yml
package:
  name: pb_bridge

sources:
  - src/pb_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/cmd_parser.sv
  - src/bus_sequencer.sv
  - src/reply_builder.sv
  - src/pb_bridge_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/pb_bridge_tb.sv
